// ==== src/vram_config.svh ====
// video dram geometry
// address and data widths shared by the design and the testbench
`ifndef VRAM_CONFIG_SVH
`define VRAM_CONFIG_SVH

// multiplexed row address width
`define VRAM_ROW_BITS 8

// column address width, same pins as the row
`define VRAM_COL_BITS 8

// one byte per location
`define VRAM_DATA_BITS 8

// bytes held in one row
// also the length of the serial register
`define VRAM_ROW_BYTES 256

`endif

// ==== src/vram_pkg.sv ====
// video dram shared types
// latched address, decoded strobes and a full row
`include "vram_config.svh"

package vram_pkg;

	// row and column as latched by the decoder
	typedef struct packed {
		logic [`VRAM_ROW_BITS-1:0] row;
		logic [`VRAM_COL_BITS-1:0] col;
	} vram_addr_t;

	// pulses and levels from the cycle decoder
	typedef struct packed {
		// byte write into the array, one per cycle
		logic wr;
		// random read in progress
		logic rd;
		// cas or oe went back high
		logic rd_end;
		// copy row into serial register
		logic xfer_load;
		// serial clock rising edge
		logic sc_rise;
		// current ras cycle is a read transfer
		logic xfer;
	} vram_strobe_t;

	// one whole row, byte 0 in the low bits
	typedef logic [`VRAM_ROW_BYTES-1:0][`VRAM_DATA_BITS-1:0] vram_row_t;

endpackage

// ==== src/vram_cycle_decode.sv ====
// video dram cycle decoder
// samples the host strobes, latches row and column, and classifies the cycle
`timescale 1ns/1ps
`include "vram_config.svh"

module vram_cycle_decode
(
	input  logic                      MCLK,
	input  logic                      i_reset,
	input  logic                      i_ras_n,
	input  logic                      i_cas_n,
	input  logic                      i_we_n,
	input  logic                      i_oe_n,
	input  logic                      i_sc,
	input  logic [`VRAM_ROW_BITS-1:0] i_ad,
	output vram_pkg::vram_addr_t      o_addr,
	output vram_pkg::vram_strobe_t    o_strobe
);
	import vram_pkg::*;

	// previous strobe levels
	logic ras_q_n;
	logic cas_q_n;
	logic oe_q_n;
	logic sc_q;

	// transfer cycle flag, decided at ras fall
	logic xfer_q;

	// column access, current and previous cycle
	logic cas_act;
	logic cas_act_q;
	logic ras_fall;

	assign cas_act   = ~i_ras_n & ~i_cas_n;
	assign cas_act_q = ~ras_q_n & ~cas_q_n;
	assign ras_fall  = ras_q_n & ~i_ras_n;

	always_ff @(posedge MCLK)
	begin
		if (i_reset)
		begin
			// strobes idle high, serial clock idle low
			ras_q_n    <= 1'b1;
			cas_q_n    <= 1'b1;
			oe_q_n     <= 1'b1;
			sc_q       <= 1'b0;
			xfer_q     <= 1'b0;
			o_addr.row <= '0;
			o_addr.col <= '0;
		end
		else
		begin
			ras_q_n <= i_ras_n;
			cas_q_n <= i_cas_n;
			oe_q_n  <= i_oe_n;
			sc_q    <= i_sc;
			// row address and cycle type at ras fall
			// oe held low here means read transfer
			if (ras_fall)
			begin
				o_addr.row <= i_ad;
				xfer_q     <= ~i_oe_n;
			end
			// column on the first cas cycle only
			if (cas_act && !cas_act_q)
				o_addr.col <= i_ad;
		end
	end

	always_comb
	begin
		// write needs the column already latched
		o_strobe.wr        = cas_act & cas_act_q & ~i_we_n;
		// no random read while a transfer is pending
		o_strobe.rd        = cas_act & ~i_oe_n & ~xfer_q;
		o_strobe.rd_end    = (i_cas_n & ~cas_q_n) | (i_oe_n & ~oe_q_n);
		// oe rising ends the transfer and loads the row
		o_strobe.xfer_load = xfer_q & i_oe_n & ~oe_q_n;
		o_strobe.sc_rise   = i_sc & ~sc_q;
		o_strobe.xfer      = xfer_q;
	end

	// transfer cycles hold we high, so a row copy and a byte write never meet
	a_wr_no_load: assert property (@(posedge MCLK) disable iff (i_reset)
		o_strobe.wr |-> !o_strobe.xfer_load);

endmodule

// ==== src/vram_array.sv ====
// video dram storage array
// 256 rows of bytes, byte write and a full-row synchronous read
`timescale 1ns/1ps
`include "vram_config.svh"

module vram_array
(
	input  logic                       MCLK,
	input  logic [`VRAM_ROW_BITS-1:0]  i_row,
	input  logic [`VRAM_COL_BITS-1:0]  i_col,
	input  logic                       i_we,
	input  logic [`VRAM_DATA_BITS-1:0] i_wdata,
	output vram_pkg::vram_row_t        o_row_data
);
	import vram_pkg::*;

	localparam int NUM_ROWS = 1 << `VRAM_ROW_BITS;

	// one entry per row, each entry a packed row of bytes
	vram_row_t mem [0:NUM_ROWS-1];

	// byte write into the addressed row
	// only the selected column changes
	always_ff @(posedge MCLK)
	begin
		if (i_we)
			mem[i_row][i_col] <= i_wdata;
	end

	// whole row read every cycle
	// a write at this edge shows up on the next read
	always_ff @(posedge MCLK)
	begin
		o_row_data <= mem[i_row];
	end

	// column comes from the decoder latch, must be settled by the write
	a_col_known: assert property (@(posedge MCLK)
		i_we |-> !$isunknown(i_col));

endmodule

// ==== src/vram_random_port.sv ====
// video dram random access port
// picks the latched column out of the read row and registers it with a valid level
`timescale 1ns/1ps
`include "vram_config.svh"

module vram_random_port
(
	input  logic                       MCLK,
	input  logic                       i_reset,
	input  logic [`VRAM_COL_BITS-1:0]  i_col,
	input  vram_pkg::vram_row_t        i_row_data,
	input  vram_pkg::vram_strobe_t     i_strobe,
	output logic [`VRAM_DATA_BITS-1:0] o_rd_data,
	output logic                       o_rd_valid
);
	import vram_pkg::*;

	// column mux stage
	logic [`VRAM_DATA_BITS-1:0] sel_q;

	// read level over the last two cycles
	logic [1:0] rd_hist;
	logic       capture;

	// capture once the column and the mux stage have settled
	assign capture = i_strobe.rd & (&rd_hist);

	// wide mux, registered every cycle
	always_ff @(posedge MCLK)
	begin
		sel_q <= i_row_data[i_col];
	end

	always_ff @(posedge MCLK)
	begin
		if (i_reset)
		begin
			rd_hist    <= 2'b00;
			o_rd_data  <= '0;
			o_rd_valid <= 1'b0;
		end
		else
		begin
			rd_hist <= {rd_hist[0], i_strobe.rd};
			// keep refreshing while the read lasts
			if (capture)
			begin
				o_rd_data  <= sel_q;
				o_rd_valid <= 1'b1;
			end
			else if (i_strobe.rd_end)
				o_rd_valid <= 1'b0;
		end
	end

	// a transfer cycle from the decoder must not start a random read
	a_no_valid_in_xfer: assert property (@(posedge MCLK) disable iff (i_reset)
		(i_strobe.xfer && !o_rd_valid) |=> !o_rd_valid);

endmodule

// ==== src/vram_serial_port.sv ====
// video dram serial access port
// row-wide shift register loaded by a read transfer, one byte out per serial clock
`timescale 1ns/1ps
`include "vram_config.svh"

module vram_serial_port
(
	input  logic                       MCLK,
	input  logic                       i_reset,
	input  logic [`VRAM_COL_BITS-1:0]  i_col,
	input  vram_pkg::vram_row_t        i_row_data,
	input  vram_pkg::vram_strobe_t     i_strobe,
	output logic [`VRAM_DATA_BITS-1:0] o_sd_data
);
	import vram_pkg::*;

	// copy of the transferred row
	vram_row_t ser;

	// next byte to send, wraps at the row end
	logic [`VRAM_COL_BITS-1:0] ptr;

	// row copy on transfer
	// later array writes leave this copy alone
	always_ff @(posedge MCLK)
	begin
		if (i_strobe.xfer_load)
			ser <= i_row_data;
	end

	always_ff @(posedge MCLK)
	begin
		if (i_reset)
		begin
			ptr       <= '0;
			o_sd_data <= '0;
		end
		else
		begin
			// start column comes from the transfer cycle
			if (i_strobe.xfer_load)
				ptr <= i_col;
			else if (i_strobe.sc_rise)
			begin
				// byte out, then step
				o_sd_data <= ser[ptr];
				// natural wrap from last column back to 0
				ptr       <= ptr + 1'b1;
			end
		end
	end

	// oe rise and sc rise come from different host cycles
	a_load_no_rise: assert property (@(posedge MCLK) disable iff (i_reset)
		i_strobe.xfer_load |-> !i_strobe.sc_rise);

endmodule

// ==== src/vram_top.sv ====
// dual ported video dram
// random access port plus a serial port fed by read transfers
`timescale 1ns/1ps
`include "vram_config.svh"

module vram_top
(
	input  logic                       MCLK,
	input  logic                       i_reset,
	input  logic                       i_ras_n,
	input  logic                       i_cas_n,
	input  logic                       i_we_n,
	input  logic                       i_oe_n,
	input  logic                       i_sc,
	input  logic                       i_se,
	input  logic [`VRAM_ROW_BITS-1:0]  i_ad,
	input  logic [`VRAM_DATA_BITS-1:0] i_rd_data,
	output logic [`VRAM_DATA_BITS-1:0] o_rd_data,
	output logic                       o_rd_valid,
	output logic [`VRAM_DATA_BITS-1:0] o_sd_data,
	output logic                       o_sd_oe
);
	import vram_pkg::*;

	// decoder outputs
	vram_addr_t   addr;
	vram_strobe_t strobe;

	// row as read from the array
	vram_row_t row_data;

	vram_cycle_decode u_decode (
		.MCLK     (MCLK),
		.i_reset  (i_reset),
		.i_ras_n  (i_ras_n),
		.i_cas_n  (i_cas_n),
		.i_we_n   (i_we_n),
		.i_oe_n   (i_oe_n),
		.i_sc     (i_sc),
		.i_ad     (i_ad),
		.o_addr   (addr),
		.o_strobe (strobe)
	);

	// write data comes straight from the host data pins
	vram_array u_array (
		.MCLK       (MCLK),
		.i_row      (addr.row),
		.i_col      (addr.col),
		.i_we       (strobe.wr),
		.i_wdata    (i_rd_data),
		.o_row_data (row_data)
	);

	vram_random_port u_random (
		.MCLK       (MCLK),
		.i_reset    (i_reset),
		.i_col      (addr.col),
		.i_row_data (row_data),
		.i_strobe   (strobe),
		.o_rd_data  (o_rd_data),
		.o_rd_valid (o_rd_valid)
	);

	vram_serial_port u_serial (
		.MCLK       (MCLK),
		.i_reset    (i_reset),
		.i_col      (addr.col),
		.i_row_data (row_data),
		.i_strobe   (strobe),
		.o_sd_data  (o_sd_data)
	);

	// serial enable passes straight to the output enable
	assign o_sd_oe = i_se;

endmodule

// ==== test/vram_checker.sv ====
// video dram output checker
// compares read and serial outputs with queued expected bytes and counts errors
`timescale 1ns/1ps
`include "vram_config.svh"

module vram_checker
(
	input logic                       MCLK,
	input logic                       i_reset,
	input logic                       i_sc,
	input logic                       i_se,
	input logic [`VRAM_DATA_BITS-1:0] i_rd_data,
	input logic                       i_rd_valid,
	input logic [`VRAM_DATA_BITS-1:0] i_sd_data,
	input logic                       i_sd_oe
);
	// cycles a queued read may wait for its valid
	localparam int READ_WAIT_MAX = 20;

	// expected bytes, oldest first
	logic [`VRAM_DATA_BITS-1:0] rd_exp_q [$];
	logic [`VRAM_DATA_BITS-1:0] sd_exp_q [$];
	logic [`VRAM_DATA_BITS-1:0] exp_byte;

	int err_count;
	int rd_checks;
	int sd_checks;

	// previous sampled levels
	logic reset_q;
	logic valid_q;
	logic sc_q;

	// cycles until the serial sample, and cycles waited on a read
	int sd_wait;
	int rd_wait;

	initial
	begin
		err_count = 0;
		rd_checks = 0;
		sd_checks = 0;
		reset_q   = 1'b1;
		valid_q   = 1'b0;
		sc_q      = 1'b0;
		sd_wait   = 0;
		rd_wait   = 0;
	end

	task expect_read(input logic [`VRAM_DATA_BITS-1:0] data);
		rd_exp_q.push_back(data);
	endtask

	task expect_serial(input logic [`VRAM_DATA_BITS-1:0] data);
		sd_exp_q.push_back(data);
	endtask

	task compare_byte(input string name, input logic [`VRAM_DATA_BITS-1:0] exp,
		input logic [`VRAM_DATA_BITS-1:0] act);
		if (act !== exp)
		begin
			$display("FAILED %s expected %h actual %h", name, exp, act);
			err_count++;
		end
	endtask

	// expectations left over at the end of the run
	task report_pending();
		if (rd_exp_q.size() != 0)
		begin
			$display("%0d expected reads were never checked", rd_exp_q.size());
			err_count += rd_exp_q.size();
		end
		if (sd_exp_q.size() != 0)
		begin
			$display("%0d expected serial bytes were never checked", sd_exp_q.size());
			err_count += sd_exp_q.size();
		end
	endtask

	always @(posedge MCLK)
	begin
		// first cycle out of reset, outputs still idle
		if (reset_q && !i_reset)
		begin
			compare_byte("o_rd_data", '0, i_rd_data);
			compare_byte("o_sd_data", '0, i_sd_data);
			if (i_rd_valid !== 1'b0)
			begin
				$display("o_rd_valid is not low after reset");
				err_count++;
			end
		end
		reset_q = i_reset;
		if (!i_reset)
		begin
			// serial enable is a plain pass-through
			if (i_sd_oe !== i_se)
			begin
				$display("FAILED o_sd_oe expected %h actual %h", i_se, i_sd_oe);
				err_count++;
			end
			// first valid cycle of a random read
			// a rise with nothing queued covers transfer cycles too
			if (i_rd_valid && !valid_q)
			begin
				if (rd_exp_q.size() == 0)
				begin
					$display("o_rd_valid rose with no random read in progress");
					err_count++;
				end
				else
				begin
					exp_byte = rd_exp_q.pop_front();
					compare_byte("o_rd_data", exp_byte, i_rd_data);
					rd_checks++;
					rd_wait = 0;
				end
			end
			else if (rd_exp_q.size() != 0)
			begin
				rd_wait++;
				if (rd_wait > READ_WAIT_MAX)
				begin
					exp_byte = rd_exp_q.pop_front();
					$display("read expecting %h never raised o_rd_valid", exp_byte);
					err_count++;
					rd_wait = 0;
				end
			end
			// serial byte, two cycles after the sc rise
			if (sd_wait == 1)
			begin
				if (sd_exp_q.size() == 0)
				begin
					$display("serial clock seen with no expected byte queued");
					err_count++;
				end
				else
				begin
					exp_byte = sd_exp_q.pop_front();
					compare_byte("o_sd_data", exp_byte, i_sd_data);
					sd_checks++;
				end
			end
			if (sd_wait != 0)
				sd_wait--;
			if (i_sc && !sc_q)
				sd_wait = 2;
		end
		valid_q = i_rd_valid;
		sc_q    = i_sc;
	end

endmodule

// ==== test/tb_vram_top.sv ====
// video dram testbench
// replays bus cycles from the vector file, checking is done in vram_checker
`timescale 1ns/1ps
`include "vram_config.svh"

module tb_vram_top;

	localparam int CLK_HALF       = 10;
	localparam int MAX_OPS        = 64;
	localparam int CYCLES_PER_OP  = 40;
	localparam int WATCHDOG_EXTRA = 200;
	localparam     VECTOR_FILE    = "test/vram_vectors.txt";

	logic                       MCLK;
	logic                       reset;
	logic                       ras_n;
	logic                       cas_n;
	logic                       we_n;
	logic                       oe_n;
	logic                       sc;
	logic                       se;
	logic [`VRAM_ROW_BITS-1:0]  ad;
	logic [`VRAM_DATA_BITS-1:0] wdata;
	logic [`VRAM_DATA_BITS-1:0] rd_data;
	logic                       rd_valid;
	logic [`VRAM_DATA_BITS-1:0] sd_data;
	logic                       sd_oe;

	// vector table: opcode, row, column, data, expected
	logic [7:0] v_op   [0:MAX_OPS-1];
	logic [7:0] v_row  [0:MAX_OPS-1];
	logic [7:0] v_col  [0:MAX_OPS-1];
	logic [7:0] v_data [0:MAX_OPS-1];
	logic [7:0] v_exp  [0:MAX_OPS-1];

	int          num_ops;
	int          tb_errors;
	int          total_errors;
	logic        vectors_loaded;
	logic        load_ok;
	logic [31:0] lcg_state;

	vram_top u_dut (
		.MCLK       (MCLK),
		.i_reset    (reset),
		.i_ras_n    (ras_n),
		.i_cas_n    (cas_n),
		.i_we_n     (we_n),
		.i_oe_n     (oe_n),
		.i_sc       (sc),
		.i_se       (se),
		.i_ad       (ad),
		.i_rd_data  (wdata),
		.o_rd_data  (rd_data),
		.o_rd_valid (rd_valid),
		.o_sd_data  (sd_data),
		.o_sd_oe    (sd_oe)
	);

	vram_checker u_check (
		.MCLK       (MCLK),
		.i_reset    (reset),
		.i_sc       (sc),
		.i_se       (se),
		.i_rd_data  (rd_data),
		.i_rd_valid (rd_valid),
		.i_sd_data  (sd_data),
		.i_sd_oe    (sd_oe)
	);

	initial
	begin
		MCLK = 1'b0;
		forever #CLK_HALF MCLK = ~MCLK;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// idle bus for 2 to 9 cycles
	task idle_gap();
		lcg_state = lcg_next(lcg_state);
		repeat (2 + lcg_state[18:16]) @(posedge MCLK);
	endtask

	task load_vectors();
		int                fd;
		int                code;
		logic              done;
		logic [7:0]        op_char;
		logic [7:0]        f_row;
		logic [7:0]        f_col;
		logic [7:0]        f_data;
		logic [7:0]        f_exp;
		logic [8*128-1:0]  skip_line;
		fd      = $fopen(VECTOR_FILE, "r");
		load_ok = (fd != 0);
		done    = (fd == 0);
		while (!done)
		begin
			code = $fscanf(fd, " %c", op_char);
			if (code != 1)
				done = 1'b1;
			else if (op_char == "#")
				code = $fgets(skip_line, fd);
			else
			begin
				code = $fscanf(fd, "%h %h %h %h", f_row, f_col, f_data, f_exp);
				if (code != 4)
				begin
					$display("vector %0d is malformed", num_ops + 1);
					tb_errors++;
					done = 1'b1;
				end
				else if (num_ops >= MAX_OPS)
				begin
					$display("vector file holds more than %0d operations", MAX_OPS);
					tb_errors++;
					done = 1'b1;
				end
				else
				begin
					v_op[num_ops]   = op_char;
					v_row[num_ops]  = f_row;
					v_col[num_ops]  = f_col;
					v_data[num_ops] = f_data;
					v_exp[num_ops]  = f_exp;
					num_ops++;
				end
			end
		end
		if (fd != 0)
			$fclose(fd);
	endtask

	// row, ras low, column with cas and we low, hold, release
	task write_byte(input logic [7:0] row, input logic [7:0] col, input logic [7:0] data);
		@(posedge MCLK);
		ad <= row;
		@(posedge MCLK);
		ras_n <= 1'b0;
		@(posedge MCLK);
		ad    <= col;
		wdata <= data;
		cas_n <= 1'b0;
		we_n  <= 1'b0;
		repeat (4) @(posedge MCLK);
		cas_n <= 1'b1;
		we_n  <= 1'b1;
		@(posedge MCLK);
		ras_n <= 1'b1;
	endtask

	// oe stays high at ras fall, so this is a plain read
	task read_byte(input logic [7:0] row, input logic [7:0] col, input logic [7:0] exp);
		@(posedge MCLK);
		u_check.expect_read(exp);
		ad   <= row;
		oe_n <= 1'b1;
		@(posedge MCLK);
		ras_n <= 1'b0;
		@(posedge MCLK);
		ad    <= col;
		cas_n <= 1'b0;
		oe_n  <= 1'b0;
		repeat (5) @(posedge MCLK);
		cas_n <= 1'b1;
		oe_n  <= 1'b1;
		@(posedge MCLK);
		ras_n <= 1'b1;
	endtask

	// oe low at ras fall marks a transfer, oe rise loads the row
	// cas and oe stay low together long enough to look like a read
	task read_transfer(input logic [7:0] row, input logic [7:0] col);
		@(posedge MCLK);
		ad   <= row;
		oe_n <= 1'b0;
		@(posedge MCLK);
		ras_n <= 1'b0;
		@(posedge MCLK);
		ad    <= col;
		cas_n <= 1'b0;
		repeat (4) @(posedge MCLK);
		oe_n <= 1'b1;
		repeat (2) @(posedge MCLK);
		cas_n <= 1'b1;
		@(posedge MCLK);
		ras_n <= 1'b1;
	endtask

	// se flips with each serial clock
	task serial_clock(input logic [7:0] exp);
		@(posedge MCLK);
		u_check.expect_serial(exp);
		se <= ~se;
		sc <= 1'b1;
		repeat (2) @(posedge MCLK);
		sc <= 1'b0;
		repeat (2) @(posedge MCLK);
	endtask

	task run_op(input int idx);
		case (v_op[idx])
			"W": write_byte(v_row[idx], v_col[idx], v_data[idx]);
			"R": read_byte(v_row[idx], v_col[idx], v_exp[idx]);
			"T": read_transfer(v_row[idx], v_col[idx]);
			"S": serial_clock(v_exp[idx]);
			default:
			begin
				$display("vector %0d has unknown opcode %c", idx + 1, v_op[idx]);
				tb_errors++;
			end
		endcase
	endtask

	initial
	begin
		wait (vectors_loaded);
		repeat (num_ops * CYCLES_PER_OP + WATCHDOG_EXTRA) @(posedge MCLK);
		$display("watchdog expired after %0d cycles with the run unfinished",
			num_ops * CYCLES_PER_OP + WATCHDOG_EXTRA);
		$display("errors %0d before the timeout", u_check.err_count + tb_errors);
		$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		// every strobe idle high, serial clock low
		reset          = 1'b1;
		ras_n          = 1'b1;
		cas_n          = 1'b1;
		we_n           = 1'b1;
		oe_n           = 1'b1;
		sc             = 1'b0;
		se             = 1'b0;
		ad             = '0;
		wdata          = '0;
		num_ops        = 0;
		tb_errors      = 0;
		lcg_state      = 32'd49797;
		vectors_loaded = 1'b0;
		load_vectors();
		if (!load_ok)
		begin
			$display("cannot open the vector file %s", VECTOR_FILE);
			$display("TEST FAIL");
			$finish;
		end
		else
		begin
			vectors_loaded = 1'b1;
			repeat (3) @(posedge MCLK);
			reset <= 1'b0;
			for (int i = 0; i < num_ops; i++)
			begin
				idle_gap();
				run_op(i);
			end
			// let the last serial sample land
			repeat (10) @(posedge MCLK);
			u_check.report_pending();
			total_errors = u_check.err_count + tb_errors;
			$display("errors %0d (checker %0d, vectors %0d), read checks %0d, serial checks %0d",
				total_errors, u_check.err_count, tb_errors, u_check.rd_checks,
				u_check.sd_checks);
			if (total_errors == 0)
				$display("TEST PASS");
			else
				$display("TEST FAIL");
			$finish;
		end
	end

endmodule

// ==== vram_top.f ====
+incdir+src
src/vram_pkg.sv
src/vram_cycle_decode.sv
src/vram_array.sv
src/vram_random_port.sv
src/vram_serial_port.sv
src/vram_top.sv
test/vram_checker.sv
test/tb_vram_top.sv

// ==== test/vram_vectors.txt ====
# op row col data expect, all hex, one bus operation per line
# W write, R read with expected byte, T read transfer, S serial clock with expected byte
W 05 10 A5 00
W 05 11 3C 00
R 05 10 00 A5
R 05 11 00 3C
W 05 10 5A 00
R 05 10 00 5A
R 05 11 00 3C
W 12 FD 11 00
W 12 FE 22 00
W 12 FF 33 00
W 12 00 44 00
W 12 01 55 00
T 12 FD 00 00
S 00 00 00 11
S 00 00 00 22
S 00 00 00 33
S 00 00 00 44
S 00 00 00 55
T 05 10 00 00
W 05 10 77 00
S 00 00 00 5A
S 00 00 00 3C
R 05 10 00 77
R 12 FF 00 33
